//--- trap_unit.f
+incdir+src
src/trap_pkg.sv
src/trap_detector.sv
src/trap_controller.sv
src/machine_csr.sv
src/trap_unit.sv
testbench/trap_unit_checker.sv
testbench/trap_unit_monitor.sv
testbench/trap_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the trap unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/trap_unit_sim

if ! verilator --binary --timing --assert -f trap_unit.f \
        --top-module trap_unit_tb -o trap_unit_sim; then
    echo "verilator build failed"
    exit 1
fi

# keep running after an assertion error so the summary is printed
if ! "$BIN" +verilator+error+limit+100 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

//--- testbench/trap_unit_tb.sv
`timescale 1ns/1ns
`include "trap_params.svh"

module trap_unit_tb;
    import trap_pkg::*;

    localparam int NUM_TESTS    = 10;
    localparam int RESET_CYCLES = 5;
    localparam int CLK_PERIOD   = 20;
    localparam int TIMEOUT_NS   = (NUM_TESTS * 20 + RESET_CYCLES) * CLK_PERIOD;

    // flag order: fetch, ebreak, ecall, mret, fencei, load, store
    localparam logic [6:0] FLAG_FETCH  = 7'b1000000;
    localparam logic [6:0] FLAG_EBREAK = 7'b0100000;
    localparam logic [6:0] FLAG_ECALL  = 7'b0010000;
    localparam logic [6:0] FLAG_MRET   = 7'b0001000;
    localparam logic [6:0] FLAG_FENCEI = 7'b0000100;
    localparam logic [6:0] FLAG_LOAD   = 7'b0000010;
    localparam logic [6:0] FLAG_STORE  = 7'b0000001;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] id_pc;
    logic [`XLEN-1:0] ex_pc;
    logic             ecall;
    logic             ebreak;
    logic             mret;
    logic             fencei;
    logic             misaligned_fetch;
    logic             misaligned_load;
    logic             misaligned_store;
    logic             csr_sw_write;
    logic [11:0]      csr_sw_addr;
    logic [`XLEN-1:0] csr_sw_wdata;
    logic [`XLEN-1:0] csr_sw_rdata;
    logic [`XLEN-1:0] trap_target;
    logic             pc_stall;
    logic             ic_clean;
    logic             debug_mode;
    logic             misaligned_instruction_flush;
    logic             misaligned_memory_flush;
    logic             pth_done_flush;
    logic             standby_mode;

    logic             start;
    trap_status_t     exp_kind;
    logic [`XLEN-1:0] exp_target;
    logic [`XLEN-1:0] exp_mepc;
    logic [`XLEN-1:0] exp_mcause;
    logic [`XLEN-1:0] exp_mtvec;
    int               exp_cycles;
    int               handled_count;
    int               done_count;
    int               pass_count;
    int               fail_count;

    logic [`XLEN-1:0] model_mepc;     // expected csr contents
    logic [`XLEN-1:0] model_mcause;
    logic [`XLEN-1:0] model_mtvec;
    integer           seed;
    int               tests_run;

    trap_unit dut (.*);

    trap_unit_monitor monitor (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected target, csr contents and handling length for one trap
    function automatic void expected_result(
        input  trap_status_t     kind,
        input  logic [`XLEN-1:0] id_val,
        input  logic [`XLEN-1:0] ex_val,
        input  logic [`XLEN-1:0] mtvec_val,
        input  logic [`XLEN-1:0] mepc_val,
        input  logic [`XLEN-1:0] mcause_val,
        output logic [`XLEN-1:0] target,
        output logic [`XLEN-1:0] mepc,
        output logic [`XLEN-1:0] mcause,
        output int               cycles
    );
        target = '0;
        mepc   = mepc_val;
        mcause = mcause_val;
        cycles = 0;
        case (kind)
            trap_misaligned_instruction: begin
                target = mtvec_val;
                mepc   = ex_val;
                mcause = `CAUSE_MISALIGNED_FETCH;
                cycles = 4;
            end
            trap_misaligned_load: begin
                target = mtvec_val;
                mepc   = ex_val;
                mcause = `CAUSE_MISALIGNED_LOAD;
                cycles = 4;
            end
            trap_misaligned_store: begin
                target = mtvec_val;
                mepc   = ex_val;
                mcause = `CAUSE_MISALIGNED_STORE;
                cycles = 4;
            end
            trap_ecall: begin
                target = mtvec_val;
                mepc   = id_val;   // saved after the standby drain
                mcause = `CAUSE_ECALL_M;
                cycles = 8;
            end
            trap_ebreak: begin
                mepc   = ex_val;
                mcause = `CAUSE_BREAKPOINT;
                cycles = 3;
            end
            trap_mret: begin
                target = (mepc_val & ~32'h3) + 32'd4;
                cycles = 3;
            end
            default: ;   // fence.i and no trap leave the csrs alone
        endcase
    endfunction

    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [`XLEN-1:0] data);
        @(posedge clk);
        csr_sw_write <= 1'b1;
        csr_sw_addr  <= addr;
        csr_sw_wdata <= data;
        @(posedge clk);
        csr_sw_write <= 1'b0;
        csr_sw_addr  <= 12'h000;
        if (addr == `CSR_MTVEC) begin
            model_mtvec = data & ~32'h3;   // direct mode
        end else if (addr == `CSR_MEPC) begin
            model_mepc = data;
        end
    endtask

    // software port sweep that the monitor compares
    task automatic read_back_csrs();
        @(posedge clk);
        csr_sw_addr <= `CSR_MEPC;
        @(posedge clk);
        csr_sw_addr <= `CSR_MCAUSE;
        @(posedge clk);
        csr_sw_addr <= `CSR_MTVEC;
        @(posedge clk);
        csr_sw_addr <= 12'h000;
    endtask

    task automatic run_trap(input trap_status_t kind, input logic [6:0] flags);
        logic [`XLEN-1:0] new_id;
        logic [`XLEN-1:0] new_ex;
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] mepc;
        logic [`XLEN-1:0] mcause;
        int               cycles;
        new_id = $random(seed);
        new_ex = $random(seed);
        expected_result(kind, new_id, new_ex, model_mtvec, model_mepc, model_mcause,
                        target, mepc, mcause, cycles);
        tests_run++;
        @(posedge clk);
        id_pc      <= new_id;
        ex_pc      <= new_ex;
        {misaligned_fetch, ebreak, ecall, mret, fencei, misaligned_load,
         misaligned_store} <= flags;
        start      <= 1'b1;
        exp_kind   <= kind;
        exp_target <= target;
        exp_mepc   <= mepc;
        exp_mcause <= mcause;
        exp_mtvec  <= model_mtvec;
        exp_cycles <= cycles;
        @(posedge clk);
        {misaligned_fetch, ebreak, ecall, mret, fencei, misaligned_load,
         misaligned_store} <= 7'b0;
        start <= 1'b0;
        wait (handled_count == tests_run);
        read_back_csrs();
        wait (done_count == tests_run);
        model_mepc   = mepc;
        model_mcause = mcause;
    endtask

    initial begin
        int assertion_failures;
        seed             = 32'h5f5de4de;
        reset            = 1'b1;
        id_pc            = '0;
        ex_pc            = '0;
        ecall            = 1'b0;
        ebreak           = 1'b0;
        mret             = 1'b0;
        fencei           = 1'b0;
        misaligned_fetch = 1'b0;
        misaligned_load  = 1'b0;
        misaligned_store = 1'b0;
        csr_sw_write     = 1'b0;
        csr_sw_addr      = 12'h000;
        csr_sw_wdata     = '0;
        start            = 1'b0;
        exp_kind         = trap_none;
        exp_target       = '0;
        exp_mepc         = '0;
        exp_mcause       = '0;
        exp_mtvec        = '0;
        exp_cycles       = 0;
        model_mepc       = '0;
        model_mcause     = '0;
        model_mtvec      = '0;
        tests_run        = 0;
        release_reset();

        run_trap(trap_none, 7'b0);   // idle outputs and zeroed csrs
        csr_write(`CSR_MTVEC, $random(seed));
        run_trap(trap_misaligned_load, FLAG_LOAD);
        run_trap(trap_misaligned_store, FLAG_STORE);
        run_trap(trap_misaligned_instruction, FLAG_FETCH);
        run_trap(trap_ecall, FLAG_ECALL);
        run_trap(trap_ebreak, FLAG_EBREAK);
        csr_write(`CSR_MEPC, $random(seed));   // low bits left random
        run_trap(trap_mret, FLAG_MRET);
        run_trap(trap_fencei, FLAG_FENCEI);
        run_trap(trap_ecall, FLAG_ECALL | FLAG_FENCEI | FLAG_LOAD);
        run_trap(trap_misaligned_instruction, FLAG_FETCH | FLAG_EBREAK | FLAG_STORE);

        assertion_failures = dut.u_controller.u_checker.failures;
        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, assertion_failures);
        if (fail_count == 0 && pass_count == NUM_TESTS && assertion_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns with %0d of %0d tests finished",
                 TIMEOUT_NS, done_count, NUM_TESTS);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- testbench/trap_unit_monitor.sv
`timescale 1ns/1ns
`include "trap_params.svh"

module trap_unit_monitor (
    input  logic                   clk,
    input  logic                   start,
    input  trap_pkg::trap_status_t exp_kind,
    input  logic [`XLEN-1:0]       exp_target,
    input  logic [`XLEN-1:0]       exp_mepc,
    input  logic [`XLEN-1:0]       exp_mcause,
    input  logic [`XLEN-1:0]       exp_mtvec,
    input  int                     exp_cycles,
    input  logic [11:0]            csr_sw_addr,
    input  logic [`XLEN-1:0]       csr_sw_rdata,
    input  logic [`XLEN-1:0]       trap_target,
    input  logic                   pc_stall,
    input  logic                   ic_clean,
    input  logic                   debug_mode,
    input  logic                   misaligned_instruction_flush,
    input  logic                   misaligned_memory_flush,
    input  logic                   pth_done_flush,
    input  logic                   standby_mode,
    output int                     handled_count,
    output int                     done_count,
    output int                     pass_count,
    output int                     fail_count
);
    import trap_pkg::*;

    int errors;   // mismatches in the running test

    task automatic check(input string what, input logic [`XLEN-1:0] got,
                         input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // wait for the testbench to put a csr address on the software port
    task automatic read_csr(input string what, input logic [11:0] addr,
                            input logic [`XLEN-1:0] exp);
        while (csr_sw_addr != addr) begin
            @(negedge clk);
        end
        check(what, csr_sw_rdata, exp);
    endtask

    initial begin
        trap_status_t kind;
        int           stall_cycles;
        int           standby_cycles;
        logic         early_flush;
        handled_count = 0;
        done_count    = 0;
        pass_count    = 0;
        fail_count    = 0;
        forever begin
            @(posedge start);
            @(negedge clk);          // expectations are settled here
            kind           = exp_kind;
            errors         = 0;
            stall_cycles   = 0;
            standby_cycles = 0;
            early_flush    = 1'b0;
            if (kind == trap_none) begin
                check_bit("pc_stall", pc_stall, 1'b0);
                check_bit("ic_clean", ic_clean, 1'b0);
                check_bit("debug_mode", debug_mode, 1'b0);
                check_bit("instruction flush", misaligned_instruction_flush, 1'b0);
                check_bit("memory flush", misaligned_memory_flush, 1'b0);
                check_bit("pth_done_flush", pth_done_flush, 1'b0);
                check_bit("standby_mode", standby_mode, 1'b0);
            end else if (kind == trap_fencei) begin
                while (!ic_clean) begin
                    @(negedge clk);
                end
                check_bit("pc_stall with ic_clean", pc_stall, 1'b0);
                @(negedge clk);
                check_bit("ic_clean one cycle later", ic_clean, 1'b0);
            end else begin
                while (!pc_stall) begin
                    @(negedge clk);
                end
                while (pc_stall) begin
                    stall_cycles++;
                    if (standby_mode) begin
                        standby_cycles++;
                    end
                    if (pth_done_flush) begin
                        early_flush = 1'b1;
                    end
                    @(negedge clk);
                end
                // last handling cycle, trap_done is high
                check("handling cycles", stall_cycles + 1, exp_cycles);
                check("standby cycles", standby_cycles, (kind == trap_ecall) ? 4 : 0);
                check_bit("pth_done_flush before last cycle", early_flush, 1'b0);
                check_bit("pth_done_flush", pth_done_flush,
                          kind != trap_ebreak && kind != trap_mret);
                check_bit("instruction flush", misaligned_instruction_flush,
                          kind == trap_misaligned_instruction);
                check_bit("memory flush", misaligned_memory_flush,
                          kind == trap_misaligned_load || kind == trap_misaligned_store);
                if (kind != trap_ebreak) begin
                    check("trap_target", trap_target, exp_target);
                end
                if (kind == trap_mret) begin
                    check_bit("debug_mode after mret", debug_mode, 1'b0);
                end
                if (kind == trap_ebreak) begin
                    @(negedge clk);   // debug_mode sets on the closing edge
                    check_bit("debug_mode after ebreak", debug_mode, 1'b1);
                end
            end
            handled_count++;
            read_csr("mepc", `CSR_MEPC, exp_mepc);
            read_csr("mcause", `CSR_MCAUSE, exp_mcause);
            read_csr("mtvec", `CSR_MTVEC, exp_mtvec);
            if (errors == 0) begin
                pass_count++;
                $display("PASS test %0d %s", done_count + 1, kind.name());
            end else begin
                fail_count++;
                $display("FAIL %0t: test %0d %s had %0d mismatches",
                         $time, done_count + 1, kind.name(), errors);
            end
            done_count++;
        end
    end

endmodule

//--- testbench/trap_unit_checker.sv
`timescale 1ns/1ns

module trap_unit_checker (
    input logic                   clk,
    input logic                   reset,
    input trap_pkg::trap_status_t trap_status,
    input trap_pkg::pth_state_t   state,
    input logic                   csr_trap_write,
    input logic                   standby_mode
);
    import trap_pkg::*;

    int failures = 0;   // summed into the testbench summary

    // no held trap means the FSM is parked
    idle_without_trap: assert property (@(posedge clk) disable iff (reset)
        (trap_status == trap_none) |-> (state == idle))
        else begin
            $error("controller is not idle while no trap is held");
            failures++;
        end

    // read states only look at the csr block
    no_write_on_read: assert property (@(posedge clk) disable iff (reset)
        (state == read_mtvec || state == return_mret) |-> !csr_trap_write)
        else begin
            $error("csr trap write raised in a read state");
            failures++;
        end

    // ecall drains the pipe for exactly four cycles
    standby_four_cycles: assert property (@(posedge clk) disable iff (reset)
        $rose(standby_mode) |-> standby_mode ##1 standby_mode ##1 standby_mode
                                ##1 standby_mode ##1 !standby_mode)
        else begin
            $error("standby_mode did not last four cycles");
            failures++;
        end

endmodule

bind trap_controller trap_unit_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .trap_status    (trap_status),
    .state          (state),
    .csr_trap_write (csr_trap_write),
    .standby_mode   (standby_mode)
);

//--- src/trap_unit.sv
`timescale 1ns/1ns
`include "trap_params.svh"

module trap_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] id_pc,
    input  logic [`XLEN-1:0] ex_pc,
    input  logic             ecall,
    input  logic             ebreak,
    input  logic             mret,
    input  logic             fencei,
    input  logic             misaligned_fetch,
    input  logic             misaligned_load,
    input  logic             misaligned_store,
    input  logic             csr_sw_write,
    input  logic [11:0]      csr_sw_addr,
    input  logic [`XLEN-1:0] csr_sw_wdata,
    output logic [`XLEN-1:0] csr_sw_rdata,
    output logic [`XLEN-1:0] trap_target,
    output logic             pc_stall,
    output logic             ic_clean,
    output logic             debug_mode,
    output logic             misaligned_instruction_flush,
    output logic             misaligned_memory_flush,
    output logic             pth_done_flush,
    output logic             standby_mode
);
    import trap_pkg::*;

    trap_status_t     trap_status;
    logic             trap_done;
    logic             csr_trap_write;
    logic [11:0]      csr_trap_addr;
    logic [`XLEN-1:0] csr_trap_wdata;
    logic [`XLEN-1:0] csr_trap_rdata;

    assign pc_stall = ~trap_done;   // hold fetch while handling runs

    trap_detector u_detector (
        .clk              (clk),
        .reset            (reset),
        .ecall            (ecall),
        .ebreak           (ebreak),
        .mret             (mret),
        .fencei           (fencei),
        .misaligned_fetch (misaligned_fetch),
        .misaligned_load  (misaligned_load),
        .misaligned_store (misaligned_store),
        .trap_done        (trap_done),
        .trap_status      (trap_status)
    );

    trap_controller u_controller (
        .clk                          (clk),
        .reset                        (reset),
        .id_pc                        (id_pc),
        .ex_pc                        (ex_pc),
        .trap_status                  (trap_status),
        .csr_trap_rdata               (csr_trap_rdata),
        .trap_target                  (trap_target),
        .ic_clean                     (ic_clean),
        .debug_mode                   (debug_mode),
        .csr_trap_write               (csr_trap_write),
        .csr_trap_addr                (csr_trap_addr),
        .csr_trap_wdata               (csr_trap_wdata),
        .trap_done                    (trap_done),
        .misaligned_instruction_flush (misaligned_instruction_flush),
        .misaligned_memory_flush      (misaligned_memory_flush),
        .pth_done_flush               (pth_done_flush),
        .standby_mode                 (standby_mode)
    );

    machine_csr u_csr (
        .clk        (clk),
        .reset      (reset),
        .trap_write (csr_trap_write),
        .trap_addr  (csr_trap_addr),
        .trap_wdata (csr_trap_wdata),
        .sw_write   (csr_sw_write),
        .sw_addr    (csr_sw_addr),
        .sw_wdata   (csr_sw_wdata),
        .trap_rdata (csr_trap_rdata),
        .sw_rdata   (csr_sw_rdata)
    );

endmodule

//--- src/machine_csr.sv
`timescale 1ns/1ns
`include "trap_params.svh"

module machine_csr (
    input  logic             clk,
    input  logic             reset,
    input  logic             trap_write,
    input  logic [11:0]      trap_addr,
    input  logic [`XLEN-1:0] trap_wdata,
    input  logic             sw_write,
    input  logic [11:0]      sw_addr,
    input  logic [`XLEN-1:0] sw_wdata,
    output logic [`XLEN-1:0] trap_rdata,
    output logic [`XLEN-1:0] sw_rdata
);
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mtvec;

    logic             wr_en;
    logic [11:0]      wr_addr;
    logic [`XLEN-1:0] wr_data;

    // unknown addresses read as zero
    function automatic logic [`XLEN-1:0] csr_read(input logic [11:0] addr);
        case (addr)
            `CSR_MEPC:   return mepc;
            `CSR_MCAUSE: return mcause;
            `CSR_MTVEC:  return mtvec;
            default:     return '0;
        endcase
    endfunction

    // trap side wins a same cycle collision
    assign wr_en   = trap_write | sw_write;
    assign wr_addr = trap_write ? trap_addr  : sw_addr;
    assign wr_data = trap_write ? trap_wdata : sw_wdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MEPC:   mepc   <= wr_data;
                `CSR_MCAUSE: mcause <= wr_data;
                `CSR_MTVEC:  mtvec  <= {wr_data[`XLEN-1:2], 2'b00};   // direct mode only
                default:     ;
            endcase
        end
    end

    // both read ports are combinational
    always_comb begin
        trap_rdata = csr_read(trap_addr);
        sw_rdata   = csr_read(sw_addr);
    end

endmodule

//--- src/trap_controller.sv
`timescale 1ns/1ns
`include "trap_params.svh"

module trap_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       id_pc,
    input  logic [`XLEN-1:0]       ex_pc,
    input  trap_pkg::trap_status_t trap_status,
    input  logic [`XLEN-1:0]       csr_trap_rdata,
    output logic [`XLEN-1:0]       trap_target,
    output logic                   ic_clean,
    output logic                   debug_mode,
    output logic                   csr_trap_write,
    output logic [11:0]            csr_trap_addr,
    output logic [`XLEN-1:0]       csr_trap_wdata,
    output logic                   trap_done,
    output logic                   misaligned_instruction_flush,
    output logic                   misaligned_memory_flush,
    output logic                   pth_done_flush,
    output logic                   standby_mode
);
    import trap_pkg::*;

    pth_state_t       state;
    pth_state_t       next_state;
    logic [`XLEN-1:0] cause_code;
    logic [`XLEN-1:0] mret_target;

    // word aligned mepc, then step past the trapping instruction
    assign mret_target = {csr_trap_rdata[`XLEN-1:2], 2'b00} + 32'd4;

    always_comb begin
        case (trap_status)
            trap_ebreak:           cause_code = `CAUSE_BREAKPOINT;
            trap_ecall:            cause_code = `CAUSE_ECALL_M;
            trap_misaligned_load:  cause_code = `CAUSE_MISALIGNED_LOAD;
            trap_misaligned_store: cause_code = `CAUSE_MISALIGNED_STORE;
            default:               cause_code = `CAUSE_MISALIGNED_FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= idle;
            debug_mode <= 1'b0;
        end else begin
            state <= next_state;
            if (trap_status == trap_mret && state == idle) begin
                debug_mode <= 1'b0;       // leave debug on mret
            end else if (trap_status == trap_ebreak && state == write_mcause) begin
                debug_mode <= 1'b1;       // ebreak handling complete
            end
        end
    end

    always_comb begin
        next_state                   = idle;
        trap_target                  = '0;
        ic_clean                     = 1'b0;
        csr_trap_write               = 1'b0;
        csr_trap_addr                = 12'h000;
        csr_trap_wdata               = '0;
        trap_done                    = 1'b1;   // idle never stalls the pc
        misaligned_instruction_flush = 1'b0;
        misaligned_memory_flush      = 1'b0;
        pth_done_flush               = 1'b0;
        standby_mode                 = 1'b0;

        case (state)
            idle: begin
                case (trap_status)
                    trap_none:   next_state = idle;
                    trap_fencei: ic_clean = 1'b1;   // single cycle, no stall
                    trap_mret: begin
                        trap_done  = 1'b0;
                        next_state = read_mepc;
                    end
                    trap_ecall: begin
                        // let older instructions drain before saving id_pc
                        standby_mode = 1'b1;
                        trap_done    = 1'b0;
                        next_state   = mem_standby;
                    end
                    default: begin
                        csr_trap_write = 1'b1;
                        csr_trap_addr  = `CSR_MEPC;
                        csr_trap_wdata = ex_pc;
                        trap_done      = 1'b0;
                        next_state     = write_mepc;
                    end
                endcase
            end
            mem_standby, wb_standby, retire_standby: begin
                standby_mode = 1'b1;
                trap_done    = 1'b0;
                next_state   = (state == mem_standby) ? wb_standby :
                               (state == wb_standby)  ? retire_standby : ecall_mepc_write;
            end
            ecall_mepc_write: begin
                csr_trap_write = 1'b1;
                csr_trap_addr  = `CSR_MEPC;
                csr_trap_wdata = id_pc;
                trap_done      = 1'b0;
                next_state     = write_mepc;
            end
            write_mepc: begin
                csr_trap_write = 1'b1;
                csr_trap_addr  = `CSR_MCAUSE;
                csr_trap_wdata = cause_code;
                trap_done      = 1'b0;
                next_state     = write_mcause;
            end
            write_mcause: begin
                if (trap_status != trap_ebreak) begin   // ebreak ends here
                    trap_done  = 1'b0;
                    next_state = read_mtvec;
                end
            end
            read_mtvec: begin
                csr_trap_addr  = `CSR_MTVEC;
                trap_target    = csr_trap_rdata;
                pth_done_flush = 1'b1;
                misaligned_instruction_flush = (trap_status == trap_misaligned_instruction);
                misaligned_memory_flush      = (trap_status == trap_misaligned_load) ||
                                               (trap_status == trap_misaligned_store);
            end
            read_mepc: begin
                csr_trap_addr = `CSR_MEPC;
                trap_done     = 1'b0;
                next_state    = return_mret;
            end
            return_mret: begin
                csr_trap_addr = `CSR_MEPC;   // keep the read address for the target
                trap_target   = mret_target;
            end
            default: next_state = idle;
        endcase
    end

endmodule

//--- src/trap_detector.sv
`timescale 1ns/1ns

module trap_detector (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ecall,
    input  logic                  ebreak,
    input  logic                  mret,
    input  logic                  fencei,
    input  logic                  misaligned_fetch,
    input  logic                  misaligned_load,
    input  logic                  misaligned_store,
    input  logic                  trap_done,
    output trap_pkg::trap_status_t trap_status
);
    import trap_pkg::*;

    trap_status_t raised;   // highest priority flag this cycle

    // fetch fault first, store fault last
    always_comb begin
        if (misaligned_fetch) begin
            raised = trap_misaligned_instruction;
        end else if (ebreak) begin
            raised = trap_ebreak;
        end else if (ecall) begin
            raised = trap_ecall;
        end else if (mret) begin
            raised = trap_mret;
        end else if (fencei) begin
            raised = trap_fencei;
        end else if (misaligned_load) begin
            raised = trap_misaligned_load;
        end else if (misaligned_store) begin
            raised = trap_misaligned_store;
        end else begin
            raised = trap_none;
        end
    end

    // hold one trap for the whole handling sequence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trap_status <= trap_none;
        end else if (trap_status == trap_none) begin
            trap_status <= raised;
        end else if (trap_done) begin
            trap_status <= trap_none;     // release after last handling cycle
        end
        // new flags are dropped while a trap is held
    end

endmodule

//--- src/trap_pkg.sv
package trap_pkg;

    // trap currently held by the detector
    typedef enum logic [2:0] {
        trap_none,
        trap_ecall,
        trap_ebreak,
        trap_mret,
        trap_fencei,
        trap_misaligned_instruction,
        trap_misaligned_load,
        trap_misaligned_store
    } trap_status_t;

    // pre-trap handling FSM states
    typedef enum logic [3:0] {
        idle,
        write_mepc,
        write_mcause,
        read_mtvec,
        read_mepc,
        return_mret,
        mem_standby,
        wb_standby,
        retire_standby,
        ecall_mepc_write
    } pth_state_t;

endpackage

//--- src/trap_params.svh
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// data and pc width, mepc alignment assumes 32
`define XLEN 32

// machine csr addresses
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVEC  12'h305

// mcause exception codes
`define CAUSE_MISALIGNED_FETCH 32'd0
`define CAUSE_BREAKPOINT       32'd3
`define CAUSE_MISALIGNED_LOAD  32'd4
`define CAUSE_MISALIGNED_STORE 32'd6
`define CAUSE_ECALL_M          32'd11

`endif
